//--- files.f
logic/dcache_geom_pkg.sv
logic/dcache_ctrl_pkg.sv
logic/dcache_array_if.sv
logic/dcache_tag_store.sv
logic/dcache_data_store.sv
logic/dcache_miss_ctrl.sv
logic/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv

//--- bench/dcache_tests.txt
// op addr wdata strb rdata refill wb wb_addr, all hex, op 1 is a store
// refill and wb flag the bus cycles a test expects, wb_addr counts only when wb is 1
// set 3, cold line then hit
0 00000134 00000000 0 3c5aa4f7 1 0 00000000
0 00000138 00000000 0 3c5aa4fb 0 0 00000000
// store miss into way 1, partial strobe
1 00000238 11223344 5 00000000 1 0 00000000
0 00000238 00000000 0 3c22a744 0 0 00000000
0 00000130 00000000 0 3c5aa4f3 0 0 00000000
// third tag evicts dirty way 1
0 00000334 00000000 0 3c5aa6f7 1 1 00000230
0 00000238 00000000 0 3c22a744 1 0 00000000
// set 5, store hits on a loaded line
0 00000050 00000000 0 3c5aa593 1 0 00000000
1 00000054 deadbeef f 00000000 0 0 00000000
0 00000054 00000000 0 deadbeef 0 0 00000000
1 00000058 cafef00d 8 00000000 0 0 00000000
0 00000058 00000000 0 ca5aa59b 0 0 00000000
0 0000005c 00000000 0 3c5aa59f 0 0 00000000
0 00001154 00000000 0 3c5ab497 1 0 00000000
0 00002158 00000000 0 3c5a849b 1 1 00000050
0 00000054 00000000 0 deadbeef 1 0 00000000
0 00000058 00000000 0 ca5aa59b 0 0 00000000

//--- bench/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_geom_pkg::*;

    localparam logic [word_width-1:0] fill_pattern = 32'h3c5a_a5c3;  // shared with mem
    localparam int fields    = 8;  // columns per test line
    localparam int max_tests = 64;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  req_valid;
    logic                  req_write;
    logic [addr_width-1:0] req_addr;
    logic [word_width-1:0] req_wdata;
    logic [strb_width-1:0] req_wstrb;
    logic [word_width-1:0] rdata;
    logic                  busy;
    logic                  mem_rd_req;
    logic [addr_width-1:0] mem_rd_addr;
    logic                  mem_rd_rdy;
    logic                  mem_ret_valid;
    logic [line_width-1:0] mem_ret_data;
    logic                  mem_wr_req;
    logic [addr_width-1:0] mem_wr_addr;
    logic [line_width-1:0] mem_wr_data;
    logic                  mem_wr_rdy;
    logic                  mem_wr_valid;

    logic [31:0] vectors [fields*max_tests];
    int          num_tests;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_errors = 0;
    int          cycle_count;
    int          cycle_limit = 0;

    always #20 clk = ~clk;

    dcache_top dut (.*);

    dcache_mem_model #(.fill_pattern(fill_pattern)) mem (.*);

    task automatic check_word(input string sig, input logic [word_width-1:0] expected,
                              input logic [word_width-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, sig, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string sig, input cache_addr_t expected,
                              input cache_addr_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, sig, expected.flat,
                     actual.flat);
            test_errors++;
        end
    endtask

    task automatic check_level(input string sig, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, sig, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("problem at %0t ns: %s", $time, what);
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_test(input int n);
        logic        is_store;
        logic [31:0] addr;
        logic [31:0] exp_rdata;
        logic        refill;
        logic        writeback;
        cache_addr_t line_addr;
        int          cycles;
        int          rd_before;
        int          wb_before;
        is_store  = vectors[n*fields][0];
        addr      = vectors[n*fields + 1];
        exp_rdata = vectors[n*fields + 4];
        refill    = vectors[n*fields + 5][0];
        writeback = vectors[n*fields + 6][0];
        rd_before = mem.rd_count;
        wb_before = mem.wb_count;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= is_store;
        req_addr  <= addr;
        req_wdata <= vectors[n*fields + 2];
        req_wstrb <= vectors[n*fields + 3][strb_width-1:0];
        @(posedge clk);
        req_valid <= 1'b0;  // accepted on this edge
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy);
        if (!is_store)
            check_word("rdata", exp_rdata, rdata);
        line_addr.flat = addr;
        line_addr.f.word = '0;
        line_addr.f.byte_off = '0;
        if (refill) begin
            if (mem.rd_count != rd_before + 1)
                report_problem("the expected refill did not happen exactly once");
            else
                check_addr("mem_rd_addr", line_addr, mem.last_rd_addr);
        end else begin
            if (mem.rd_count != rd_before)
                report_problem("a hit went to memory for a refill");
            if (cycles != (is_store ? 2 : 1))
                report_problem($sformatf("the hit took %0d cycles", cycles));
        end
        if (writeback) begin
            if (mem.wb_count != wb_before + 1)
                report_problem("the expected writeback did not happen exactly once");
            else
                check_addr("mem_wr_addr", cache_addr_t'(vectors[n*fields + 7]), mem.last_wb_addr);
        end else if (mem.wb_count != wb_before) begin
            report_problem("a writeback happened that was not expected");
        end
        finish_test($sformatf("test %0d %s %h", n + 1, is_store ? "store" : "load", addr));
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_limit == 0 || cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        for (int i = 0; i < fields*max_tests; i++)
            vectors[i] = '1;  // all ones marks the end
        $readmemh("bench/dcache_tests.txt", vectors);
        num_tests = 0;
        while (num_tests < max_tests && vectors[num_tests*fields] <= 1)
            num_tests++;
        cycle_limit = num_tests * 64;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_level("busy", 1'b0, busy);
        check_level("mem_rd_req", 1'b0, mem_rd_req);
        check_level("mem_wr_req", 1'b0, mem_wr_req);
        finish_test("reset state");
        if (num_tests == 0) begin
            report_problem("no tests were found in the test file");
            finish_test("test file");
        end
        for (int n = 0; n < num_tests; n++)
            run_test(n);
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- bench/dcache_mem_model.sv
module dcache_mem_model #(
    parameter logic [dcache_geom_pkg::word_width-1:0] fill_pattern = '0
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   mem_rd_req,
    input  logic [dcache_geom_pkg::addr_width-1:0] mem_rd_addr,
    output logic                                   mem_rd_rdy,
    output logic                                   mem_ret_valid,
    output logic [dcache_geom_pkg::line_width-1:0] mem_ret_data,
    input  logic                                   mem_wr_req,
    input  logic [dcache_geom_pkg::addr_width-1:0] mem_wr_addr,
    input  logic [dcache_geom_pkg::line_width-1:0] mem_wr_data,
    output logic                                   mem_wr_rdy,
    output logic                                   mem_wr_valid
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_geom_pkg::*;

    localparam int mem_words = 4096;  // 16 KB

    logic [word_width-1:0] words [mem_words];
    cache_addr_t           last_rd_addr;
    cache_addr_t           last_wb_addr;
    logic [line_width-1:0] last_wb_line;
    int                    rd_count;
    int                    wb_count;
    integer                seed;

    function automatic int word_index(input cache_addr_t a);
        return int'(a.flat[13:2]);
    endfunction

    // 0 to 3 cycles of memory latency
    task automatic wait_random();
        int n;
        n = {$random(seed)} % 4;
        repeat (n) @(posedge clk);
    endtask

    initial begin
        seed = 21;
        rd_count = 0;
        wb_count = 0;
        mem_rd_rdy = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data = '0;
        mem_wr_rdy = 1'b0;
        mem_wr_valid = 1'b0;
        for (int i = 0; i < mem_words; i++)
            words[i] = word_width'(i * 4) ^ fill_pattern;  // byte address of the word
        forever begin
            @(posedge clk);
            if (!reset && mem_wr_req) begin
                wait_random();
                last_wb_addr.flat = mem_wr_addr;
                last_wb_line = mem_wr_data;
                mem_wr_rdy <= 1'b1;
                @(posedge clk);
                mem_wr_rdy <= 1'b0;
                wait_random();
                for (int k = 0; k < words_per_line; k++)
                    words[word_index(last_wb_addr) + k] = last_wb_line[k*word_width +: word_width];
                wb_count++;
                mem_wr_valid <= 1'b1;
                @(posedge clk);
                mem_wr_valid <= 1'b0;
            end else if (!reset && mem_rd_req) begin
                wait_random();
                last_rd_addr.flat = mem_rd_addr;
                mem_rd_rdy <= 1'b1;
                @(posedge clk);
                mem_rd_rdy <= 1'b0;
                wait_random();
                for (int k = 0; k < words_per_line; k++)
                    mem_ret_data[k*word_width +: word_width] <= words[word_index(last_rd_addr) + k];
                rd_count++;
                mem_ret_valid <= 1'b1;  // whole line in one beat
                @(posedge clk);
                mem_ret_valid <= 1'b0;
            end
        end
    end

endmodule

//--- logic/dcache_top.sv
module dcache_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   req_valid,
    input  logic                                   req_write,
    input  logic [dcache_geom_pkg::addr_width-1:0] req_addr,
    input  logic [dcache_geom_pkg::word_width-1:0] req_wdata,
    input  logic [dcache_geom_pkg::strb_width-1:0] req_wstrb,
    output logic [dcache_geom_pkg::word_width-1:0] rdata,
    output logic                                   busy,
    output logic                                   mem_rd_req,
    output logic [dcache_geom_pkg::addr_width-1:0] mem_rd_addr,
    input  logic                                   mem_rd_rdy,
    input  logic                                   mem_ret_valid,
    input  logic [dcache_geom_pkg::line_width-1:0] mem_ret_data,
    output logic                                   mem_wr_req,
    output logic [dcache_geom_pkg::addr_width-1:0] mem_wr_addr,
    output logic [dcache_geom_pkg::line_width-1:0] mem_wr_data,
    input  logic                                   mem_wr_rdy,
    input  logic                                   mem_wr_valid
);

    dcache_array_if arr ();

    dcache_miss_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wstrb     (req_wstrb),
        .rdata         (rdata),
        .busy          (busy),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_valid  (mem_wr_valid),
        .arr           (arr.ctrl)
    );

    dcache_tag_store u_tags (
        .clk   (clk),
        .reset (reset),
        .arr   (arr.tags)
    );

    dcache_data_store u_data (
        .clk (clk),
        .arr (arr.data)
    );

endmodule

//--- logic/dcache_miss_ctrl.sv
module dcache_miss_ctrl (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   req_valid,
    input  logic                                   req_write,
    input  logic [dcache_geom_pkg::addr_width-1:0] req_addr,
    input  logic [dcache_geom_pkg::word_width-1:0] req_wdata,
    input  logic [dcache_geom_pkg::strb_width-1:0] req_wstrb,
    output logic [dcache_geom_pkg::word_width-1:0] rdata,
    output logic                                   busy,
    output logic                                   mem_rd_req,
    output logic [dcache_geom_pkg::addr_width-1:0] mem_rd_addr,
    input  logic                                   mem_rd_rdy,
    input  logic                                   mem_ret_valid,
    input  logic [dcache_geom_pkg::line_width-1:0] mem_ret_data,
    output logic                                   mem_wr_req,
    output logic [dcache_geom_pkg::addr_width-1:0] mem_wr_addr,
    output logic [dcache_geom_pkg::line_width-1:0] mem_wr_data,
    input  logic                                   mem_wr_rdy,
    input  logic                                   mem_wr_valid,
    dcache_array_if.ctrl                           arr
);
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;

    cache_addr_t              req_a;
    cache_addr_t              buf_addr;
    logic                     buf_valid;
    logic                     buf_write;
    logic [word_width-1:0]    buf_wdata;
    logic [strb_width-1:0]    buf_wstrb;
    logic [state_width-1:0]   state;
    logic [state_width-1:0]   state_nx;
    logic                     accept;
    logic                     in_lookup;
    logic [num_ways-1:0]      hit_vec;
    logic                     hit;
    logic [way_sel_width-1:0] hit_way;
    logic [line_width-1:0]    hit_line;
    logic [word_width-1:0]    hit_word;
    logic [word_width-1:0]    merged;
    logic                     victim_dirty;

    assign req_a.flat = req_addr;
    assign in_lookup  = (state == st_lookup);
    assign accept     = req_valid && !busy;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = arr.valid_q[w] && (arr.tag_q[w] == buf_addr.f.tag);
            if (hit_vec[w])
                hit_way = way_sel_width'(w);
        end
    end

    assign hit      = |hit_vec;
    assign hit_line = arr.line_q[hit_way];
    assign hit_word = hit_line[buf_addr.f.word*word_width +: word_width];
    assign rdata    = hit_word;

    always_comb begin
        for (int b = 0; b < strb_width; b++)
            merged[b*8 +: 8] = buf_wstrb[b] ? buf_wdata[b*8 +: 8] : hit_word[b*8 +: 8];
    end

    // a store hit costs one cycle and a miss holds until the re-read hits
    assign busy = !in_lookup || (buf_valid && (!hit || buf_write));

    always_ff @(posedge clk) begin
        if (reset)
            buf_valid <= 1'b0;
        else if (accept)
            buf_valid <= 1'b1;
        else if (in_lookup && hit)
            buf_valid <= 1'b0;  // request done
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr.flat <= req_addr;
            buf_write     <= req_write;
            buf_wdata     <= req_wdata;
            buf_wstrb     <= req_wstrb;
        end
    end

    assign victim_dirty = arr.valid_q[arr.victim_way] && arr.dirty_q[arr.victim_way];

    always_ff @(posedge clk) begin
        if (reset)
            state <= st_lookup;
        else
            state <= state_nx;
    end

    always_comb begin
        state_nx = state;
        case (state)
            st_lookup:
                if (buf_valid && !hit)
                    state_nx = victim_dirty ? st_miss_dirty : st_miss_clean;
            st_miss_dirty:
                if (mem_wr_rdy)
                    state_nx = st_writeback;
            st_writeback:
                if (mem_wr_valid)
                    state_nx = st_miss_clean;
            st_miss_clean:
                if (mem_rd_rdy)
                    state_nx = st_refill;
            st_refill:
                if (mem_ret_valid)
                    state_nx = st_refill_done;
            default:
                state_nx = st_lookup;
        endcase
    end

    assign arr.rd_en    = accept || (state == st_refill_done);
    assign arr.rd_index = accept ? req_a.f.index : buf_addr.f.index;
    assign arr.wr_index = buf_addr.f.index;

    always_comb begin
        arr.refill_way_we = '0;
        if (state == st_refill && mem_ret_valid)
            arr.refill_way_we[arr.victim_way] = 1'b1;
    end

    assign arr.refill_tag   = buf_addr.f.tag;
    assign arr.refill_line  = mem_ret_data;
    assign arr.store_way_we = (in_lookup && buf_valid && buf_write) ? hit_vec : '0;
    assign arr.store_word   = buf_addr.f.word;
    assign arr.store_data   = merged;
    assign arr.plru_update  = in_lookup && buf_valid && hit;
    assign arr.plru_hit_way = hit_way;

    // victim tag and line still sit in the read registers
    assign mem_rd_req  = (state == st_miss_clean);
    assign mem_rd_addr = {buf_addr.f.tag, buf_addr.f.index, {offset_width{1'b0}}};
    assign mem_wr_req  = (state == st_miss_dirty);
    assign mem_wr_addr = {arr.tag_q[arr.victim_way], buf_addr.f.index, {offset_width{1'b0}}};
    assign mem_wr_data = arr.line_q[arr.victim_way];

    // write bus only for a valid dirty victim and never beside a refill request
    a_bus_excl: assert property (
        @(posedge clk) disable iff (reset) mem_wr_req |-> !mem_rd_req && victim_dirty
    );

    // cpu has to wait out busy
    a_no_req_busy: assert property (
        @(posedge clk) disable iff (reset) busy |-> !req_valid
    );

endmodule

//--- logic/dcache_data_store.sv
module dcache_data_store (
    input logic          clk,
    dcache_array_if.data arr
);
    import dcache_geom_pkg::*;

    // one word ram per way and word position
    logic [word_width-1:0] ram [num_ways][words_per_line][num_sets];

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            for (int k = 0; k < words_per_line; k++) begin
                if (arr.refill_way_we[w]) begin
                    ram[w][k][arr.wr_index] <= arr.refill_line[k*word_width +: word_width];
                end else if (arr.store_way_we[w] &&
                             arr.store_word == word_sel_width'(k)) begin
                    ram[w][k][arr.wr_index] <= arr.store_data;
                end
            end
        end
    end

    // registered read that holds while rd_en is low
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < num_ways; w++) begin
                for (int k = 0; k < words_per_line; k++)
                    arr.line_q[w][k*word_width +: word_width] <= ram[w][k][arr.rd_index];
            end
        end
    end

endmodule

//--- logic/dcache_tag_store.sv
module dcache_tag_store (
    input logic          clk,
    input logic          reset,
    dcache_array_if.tags arr
);
    import dcache_geom_pkg::*;

    logic [tag_width-1:0] tag_mem [num_ways][num_sets];
    logic [num_sets-1:0]  valid_bits [num_ways];
    logic [num_sets-1:0]  dirty_bits [num_ways];
    logic [num_sets-1:0]  plru_bits;  // 1 = replace way 1 next
    logic                 plru_fwd;

    // tag ram, written only on refill
    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (arr.refill_way_we[w])
                tag_mem[w][arr.wr_index] <= arr.refill_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_bits[w] <= '0;
                dirty_bits[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (arr.refill_way_we[w]) begin
                    valid_bits[w][arr.wr_index] <= 1'b1;
                    dirty_bits[w][arr.wr_index] <= 1'b0;  // fresh line is clean
                end else if (arr.store_way_we[w]) begin
                    dirty_bits[w][arr.wr_index] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            plru_bits <= '0;
        else if (arr.plru_update)
            plru_bits[arr.wr_index] <= ~arr.plru_hit_way;  // point away from the hit
    end

    // update to the set being read in the same cycle
    assign plru_fwd = arr.plru_update && (arr.wr_index == arr.rd_index);

    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            for (int w = 0; w < num_ways; w++) begin
                arr.tag_q[w]   <= tag_mem[w][arr.rd_index];
                arr.valid_q[w] <= valid_bits[w][arr.rd_index];
                arr.dirty_q[w] <= dirty_bits[w][arr.rd_index];
            end
            arr.victim_way <= plru_fwd ? ~arr.plru_hit_way : plru_bits[arr.rd_index];
        end
    end

    // refill and store writes come from different controller states
    a_one_way_write: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({arr.refill_way_we, arr.store_way_we})
    );

endmodule

//--- logic/dcache_array_if.sv
interface dcache_array_if ();
    import dcache_geom_pkg::*;

    logic                                rd_en;
    logic [index_width-1:0]              rd_index;
    logic [index_width-1:0]              wr_index;
    logic [num_ways-1:0]                 refill_way_we;
    logic [tag_width-1:0]                refill_tag;
    logic [line_width-1:0]               refill_line;
    logic [num_ways-1:0]                 store_way_we;
    logic [word_sel_width-1:0]           store_word;
    logic [word_width-1:0]               store_data;
    logic                                plru_update;
    logic [way_sel_width-1:0]            plru_hit_way;

    logic [num_ways-1:0][tag_width-1:0]  tag_q;
    logic [num_ways-1:0]                 valid_q;
    logic [num_ways-1:0]                 dirty_q;
    logic [num_ways-1:0][line_width-1:0] line_q;
    logic [way_sel_width-1:0]            victim_way;  // plru bit of the set last read

    modport ctrl (
        output rd_en, rd_index, wr_index, refill_way_we, refill_tag, refill_line,
               store_way_we, store_word, store_data, plru_update, plru_hit_way,
        input  tag_q, valid_q, dirty_q, line_q, victim_way
    );

    modport tags (
        input  rd_en, rd_index, wr_index, refill_way_we, refill_tag, store_way_we,
               plru_update, plru_hit_way,
        output tag_q, valid_q, dirty_q, victim_way
    );

    modport data (
        input  rd_en, rd_index, wr_index, refill_way_we, refill_line, store_way_we,
               store_word, store_data,
        output line_q
    );

endinterface

//--- logic/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    localparam int state_width = 3;

    // miss controller states
    localparam logic [state_width-1:0] st_lookup      = 3'd0;
    localparam logic [state_width-1:0] st_miss_dirty  = 3'd1;  // asking for write bus
    localparam logic [state_width-1:0] st_writeback   = 3'd2;  // waiting for write done
    localparam logic [state_width-1:0] st_miss_clean  = 3'd3;  // asking for read bus
    localparam logic [state_width-1:0] st_refill      = 3'd4;  // waiting for line
    localparam logic [state_width-1:0] st_refill_done = 3'd5;  // re-read of the set

endpackage

//--- logic/dcache_geom_pkg.sv
package dcache_geom_pkg;

    localparam int addr_width     = 32;
    localparam int word_width     = 32;
    localparam int words_per_line = 4;
    localparam int num_ways       = 2;
    localparam int num_sets       = 16;

    localparam int strb_width     = word_width / 8;
    localparam int word_sel_width = $clog2(words_per_line);
    localparam int byte_sel_width = $clog2(strb_width);
    localparam int way_sel_width  = $clog2(num_ways);
    localparam int offset_width   = word_sel_width + byte_sel_width;  // 4
    localparam int index_width    = $clog2(num_sets);                 // 4
    localparam int tag_width      = addr_width - index_width - offset_width;
    localparam int line_width     = word_width * words_per_line;

    // same address seen flat or split into cache fields
    typedef union packed {
        logic [addr_width-1:0] flat;
        struct packed {
            logic [tag_width-1:0]      tag;
            logic [index_width-1:0]    index;
            logic [word_sel_width-1:0] word;
            logic [byte_sel_width-1:0] byte_off;
        } f;
    } cache_addr_t;

endpackage
